/* ps2_kbd_top.f */
+incdir+.
ps2_kbd_pkg.sv
ps2_frame_rx.sv
scan_fifo.sv
hex_seg_decoder.sv
dec_seg_decoder.sv
seg_display.sv
ps2_kbd_top.sv
ps2_kbd_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it, the log decides pass or fail
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --top-module ps2_kbd_tb -f ps2_kbd_top.f > sim.log 2>&1 &&
    ./obj_dir/Vps2_kbd_tb >> sim.log 2>&1 ||
    echo "TEST FAILED" >> sim.log

cat sim.log
if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0

/* ps2_kbd_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ps2_kbd_consts.svh"

module ps2_kbd_tb;

    localparam int PHASE_CYCLES   = 10;  // clk cycles per half of a PS/2 clock
    localparam int FRAME_CYCLES   = 11 * 2 * PHASE_CYCLES + 10;
    localparam int TIMEOUT_CYCLES = 40 * FRAME_CYCLES + 2800;
    localparam int READY_LIMIT    = 10;
    localparam int FAULT_NONE     = 0;
    localparam int FAULT_PARITY   = 1;
    localparam int FAULT_START    = 2;
    localparam int FAULT_STOP     = 3;

    logic                    clk;
    logic                    reset;
    logic                    ps2_clk;
    logic                    ps2_data;
    logic                    next_n;
    ps2_kbd_pkg::scan_byte_t data;
    logic                    ready;
    logic                    overflow;
    ps2_kbd_pkg::seg_bank_t  segs;

    int                      cycle_count;
    int                      errors;
    int                      passes;
    ps2_kbd_pkg::scan_byte_t sent_q[$];

    ps2_kbd_top UUT (
        .clk      (clk),
        .reset    (reset),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .next_n   (next_n),
        .data     (data),
        .ready    (ready),
        .overflow (overflow),
        .segs     (segs)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model and compare tasks
    ////////////////////////////////////////////////////////////////////////////
    function automatic ps2_kbd_pkg::seg_t glyph_for(input int d);
        ps2_kbd_pkg::seg_t g;
        case (d)
            0:       g = `SEG_DIGIT_0;
            1:       g = `SEG_DIGIT_1;
            2:       g = `SEG_DIGIT_2;
            3:       g = `SEG_DIGIT_3;
            4:       g = `SEG_DIGIT_4;
            5:       g = `SEG_DIGIT_5;
            6:       g = `SEG_DIGIT_6;
            7:       g = `SEG_DIGIT_7;
            8:       g = `SEG_DIGIT_8;
            9:       g = `SEG_DIGIT_9;
            10:      g = `SEG_DIGIT_A;
            11:      g = `SEG_DIGIT_B;
            12:      g = `SEG_DIGIT_C;
            13:      g = `SEG_DIGIT_D;
            14:      g = `SEG_DIGIT_E;
            15:      g = `SEG_DIGIT_F;
            default: g = `SEG_BLANK;
        endcase
        return g;
    endfunction

    function automatic ps2_kbd_pkg::seg_bank_t expected_segs(
        input ps2_kbd_pkg::scan_byte_t b,
        input logic                    shown
    );
        ps2_kbd_pkg::seg_bank_t s;
        int                     v;
        v = int'(b);
        s.hex_lo   = `SEG_BLANK;
        s.hex_hi   = `SEG_BLANK;
        s.dec_ones = `SEG_BLANK;
        s.dec_tens = `SEG_BLANK;
        if (shown) begin
            s.hex_lo   = glyph_for(v % 16);
            s.hex_hi   = glyph_for(v / 16);
            s.dec_ones = glyph_for((v % 100) % 10);  // only the last two decimal digits
            s.dec_tens = glyph_for((v % 100) / 10);
        end
        return s;
    endfunction

    task automatic check_byte(input string what, input ps2_kbd_pkg::scan_byte_t got,
                              input ps2_kbd_pkg::scan_byte_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end else begin
            passes++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end else begin
            passes++;
        end
    endtask

    task automatic check_segs(input string what, input ps2_kbd_pkg::seg_bank_t got,
                              input ps2_kbd_pkg::seg_bank_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end else begin
            passes++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // keyboard model and consumer
    ////////////////////////////////////////////////////////////////////////////
    function automatic ps2_kbd_pkg::scan_byte_t random_byte();
        return ps2_kbd_pkg::scan_byte_t'($urandom());
    endfunction

    // returns right after the falling edge of the stop bit
    task automatic send_frame(input ps2_kbd_pkg::scan_byte_t b, input int fault);
        logic [10:0] bits;
        logic        parity;
        parity = ~^b;  // odd over data and parity
        if (fault == FAULT_PARITY) begin
            parity = ~parity;
        end
        bits = {(fault != FAULT_STOP), parity, b, (fault == FAULT_START)};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            ps2_clk  <= 1'b1;
            ps2_data <= bits[i];
            repeat (PHASE_CYCLES) @(posedge clk);
            ps2_clk <= 1'b0;  // the receiver samples here
            if (i < 10) begin
                repeat (PHASE_CYCLES - 1) @(posedge clk);
            end
        end
    endtask

    task automatic finish_frame();
        repeat (PHASE_CYCLES) @(posedge clk);
        ps2_clk <= 1'b1;
        repeat (PHASE_CYCLES) @(posedge clk);
    endtask

    task automatic send_byte(input ps2_kbd_pkg::scan_byte_t b);
        send_frame(b, FAULT_NONE);
        finish_frame();
        sent_q.push_back(b);
    endtask

    task automatic wait_ready(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!ready && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!ready) begin
            $display("ready did not rise within %0d cycles at time %0t", limit, $time);
            errors++;
        end
    endtask

    // checks the head entry and its digits, then strobes next_n for one cycle
    task automatic pop_and_compare(input ps2_kbd_pkg::scan_byte_t exp);
        @(negedge clk);
        check_flag("ready", ready, 1'b1);
        check_byte("data", data, exp);
        check_segs("segs", segs, expected_segs(exp, 1'b1));
        @(posedge clk);
        next_n <= 1'b0;
        @(posedge clk);
        next_n <= 1'b1;
    endtask

    task automatic drain_queue();
        while (sent_q.size() > 0) begin
            pop_and_compare(sent_q.pop_front());
        end
        @(negedge clk);
        check_flag("ready", ready, 1'b0);
        check_segs("segs", segs, expected_segs(8'h00, 1'b0));
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%s: %s", name, (errors == errors_before) ? "passed" : "failed");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic idle_after_reset();
        int e;
        e = errors;
        @(negedge clk);
        check_flag("ready", ready, 1'b0);
        check_flag("overflow", overflow, 1'b0);
        check_segs("segs", segs, expected_segs(8'h00, 1'b0));
        report_test("idle after reset", e);
    endtask

    task automatic receive_single_frame();
        int                      e;
        ps2_kbd_pkg::scan_byte_t b;
        e = errors;
        b = random_byte();
        send_frame(b, FAULT_NONE);
        wait_ready(READY_LIMIT);
        finish_frame();
        sent_q.push_back(b);
        drain_queue();
        report_test("single frame", e);
    endtask

    task automatic stream_five_bytes();
        int e;
        e = errors;
        repeat (5) send_byte(random_byte());
        drain_queue();
        report_test("five bytes in order", e);
    endtask

    task automatic drop_bad_frames();
        int e;
        e = errors;
        for (int f = FAULT_PARITY; f <= FAULT_STOP; f++) begin
            send_frame(random_byte(), f);
            finish_frame();
            repeat (READY_LIMIT) @(negedge clk);
            check_flag("ready after bad frame", ready, 1'b0);
        end
        send_byte(random_byte());
        drain_queue();
        report_test("bad frames dropped", e);
    endtask

    task automatic fill_past_full();
        int e;
        e = errors;
        repeat (`PS2_FIFO_DEPTH) send_byte(random_byte());
        @(negedge clk);
        check_flag("overflow when full", overflow, 1'b0);
        send_frame(random_byte(), FAULT_NONE);  // this one has no room
        finish_frame();
        @(negedge clk);
        check_flag("overflow", overflow, 1'b1);
        drain_queue();
        check_flag("overflow after drain", overflow, 1'b1);
        apply_reset();
        @(negedge clk);
        check_flag("overflow after reset", overflow, 1'b0);
        report_test("overflow", e);
    endtask

    // sweeps the pop strobe across the write so one offset lands on it
    task automatic pop_during_write();
        int                      e;
        ps2_kbd_pkg::scan_byte_t c;
        e = errors;
        for (int k = 0; k < 7; k++) begin
            send_byte(random_byte());
            send_byte(random_byte());
            c = random_byte();
            send_frame(c, FAULT_NONE);
            repeat (k) @(posedge clk);
            @(posedge clk);
            next_n <= 1'b0;
            @(posedge clk);
            next_n <= 1'b1;
            void'(sent_q.pop_front());
            sent_q.push_back(c);
            repeat (8) begin
                @(negedge clk);
                check_flag("ready around pop", ready, 1'b1);
            end
            finish_frame();
            drain_queue();
        end
        report_test("pop during write", e);
    endtask

    initial begin
        reset       = 1'b1;
        ps2_clk     = 1'b1;
        ps2_data    = 1'b1;
        next_n      = 1'b1;
        cycle_count = 0;
        errors      = 0;
        passes      = 0;
        void'($urandom(13005));
        apply_reset();
        idle_after_reset();
        receive_single_frame();
        stream_five_bytes();
        drop_bad_frames();
        fill_past_full();
        pop_during_write();
        $display("checks passed: %0d, checks failed: %0d", passes, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ps2_kbd_top.sv */
`timescale 1ns/10ps
`default_nettype none

module ps2_kbd_top (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               ps2_clk,
    input  wire logic               ps2_data,
    input  wire logic               next_n,   // low pops the shown byte
    output ps2_kbd_pkg::scan_byte_t data,
    output logic                    ready,
    output logic                    overflow,
    output ps2_kbd_pkg::seg_bank_t  segs
);

    logic                    byte_valid;
    ps2_kbd_pkg::scan_byte_t rx_byte;
    ps2_kbd_pkg::seg_bank_t  hex_segs;
    ps2_kbd_pkg::seg_bank_t  dec_segs;

    ////////////////////////////////////////////////////////////////////////////
    // receive chain
    ////////////////////////////////////////////////////////////////////////////
    ps2_frame_rx u_rx (
        .clk        (clk),
        .reset      (reset),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .byte_valid (byte_valid),
        .byte_out   (rx_byte)
    );

    scan_fifo #(.payload_t(ps2_kbd_pkg::scan_byte_t)) u_fifo (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (byte_valid),
        .wr_data  (rx_byte),
        .next_n   (next_n),
        .data     (data),
        .ready    (ready),
        .overflow (overflow)
    );

    ////////////////////////////////////////////////////////////////////////////
    // both decoders look at the FIFO head
    ////////////////////////////////////////////////////////////////////////////
    hex_seg_decoder u_hex (
        .data (data),
        .segs (hex_segs)
    );

    dec_seg_decoder u_dec (
        .data (data),
        .segs (dec_segs)
    );

    seg_display u_disp (
        .hex_segs (hex_segs),
        .dec_segs (dec_segs),
        .ready    (ready),
        .segs     (segs)
    );

endmodule

`default_nettype wire

/* seg_display.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ps2_kbd_consts.svh"

module seg_display (
    input  wire ps2_kbd_pkg::seg_bank_t hex_segs,
    input  wire ps2_kbd_pkg::seg_bank_t dec_segs,
    input  wire logic                   ready,
    output ps2_kbd_pkg::seg_bank_t      segs
);

    ps2_kbd_pkg::seg_bank_t merged;

    ////////////////////////////////////////////////////////////////////////////
    // take the hex digits from one decoder and the decimal ones from the other
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        merged.hex_lo   = hex_segs.hex_lo;
        merged.hex_hi   = hex_segs.hex_hi;
        merged.dec_ones = dec_segs.dec_ones;
        merged.dec_tens = dec_segs.dec_tens;
    end

    // the FIFO head is stale when nothing is ready, so show nothing
    always_comb begin
        if (ready) begin
            segs = merged;
        end else begin
            segs.hex_lo   = `SEG_BLANK;
            segs.hex_hi   = `SEG_BLANK;
            segs.dec_ones = `SEG_BLANK;
            segs.dec_tens = `SEG_BLANK;
        end
    end

endmodule

`default_nettype wire

/* dec_seg_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ps2_kbd_consts.svh"

module dec_seg_decoder (
    input  wire ps2_kbd_pkg::scan_byte_t data,
    output ps2_kbd_pkg::seg_bank_t       segs
);

    logic [7:0] mod_val;  // 0 to 99
    logic [3:0] tens;
    logic [3:0] ones;

    function automatic ps2_kbd_pkg::seg_t dec_glyph(input logic [3:0] digit);
        ps2_kbd_pkg::seg_t glyph;
        case (digit)
            4'd0:    glyph = `SEG_DIGIT_0;
            4'd1:    glyph = `SEG_DIGIT_1;
            4'd2:    glyph = `SEG_DIGIT_2;
            4'd3:    glyph = `SEG_DIGIT_3;
            4'd4:    glyph = `SEG_DIGIT_4;
            4'd5:    glyph = `SEG_DIGIT_5;
            4'd6:    glyph = `SEG_DIGIT_6;
            4'd7:    glyph = `SEG_DIGIT_7;
            4'd8:    glyph = `SEG_DIGIT_8;
            4'd9:    glyph = `SEG_DIGIT_9;
            default: glyph = `SEG_BLANK;  // never hit for a mod 100 value
        endcase
        return glyph;
    endfunction

    // split the value mod 100 into its two decimal digits
    assign mod_val = data % 8'd100;
    assign tens    = 4'(mod_val / 8'd10);
    assign ones    = 4'(mod_val % 8'd10);

    always_comb begin
        segs.hex_lo   = `SEG_BLANK;
        segs.hex_hi   = `SEG_BLANK;
        segs.dec_ones = dec_glyph(ones);
        segs.dec_tens = dec_glyph(tens);
    end

endmodule

`default_nettype wire

/* hex_seg_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ps2_kbd_consts.svh"

module hex_seg_decoder (
    input  wire ps2_kbd_pkg::scan_byte_t data,
    output ps2_kbd_pkg::seg_bank_t       segs
);

    function automatic ps2_kbd_pkg::seg_t hex_glyph(input logic [3:0] nibble);
        ps2_kbd_pkg::seg_t glyph;
        case (nibble)
            4'h0: glyph = `SEG_DIGIT_0;
            4'h1: glyph = `SEG_DIGIT_1;
            4'h2: glyph = `SEG_DIGIT_2;
            4'h3: glyph = `SEG_DIGIT_3;
            4'h4: glyph = `SEG_DIGIT_4;
            4'h5: glyph = `SEG_DIGIT_5;
            4'h6: glyph = `SEG_DIGIT_6;
            4'h7: glyph = `SEG_DIGIT_7;
            4'h8: glyph = `SEG_DIGIT_8;
            4'h9: glyph = `SEG_DIGIT_9;
            4'ha: glyph = `SEG_DIGIT_A;
            4'hb: glyph = `SEG_DIGIT_B;
            4'hc: glyph = `SEG_DIGIT_C;
            4'hd: glyph = `SEG_DIGIT_D;
            4'he: glyph = `SEG_DIGIT_E;
            4'hf: glyph = `SEG_DIGIT_F;
        endcase
        return glyph;
    endfunction

    always_comb begin
        segs.hex_lo   = hex_glyph(data[3:0]);
        segs.hex_hi   = hex_glyph(data[7:4]);
        segs.dec_ones = `SEG_BLANK;  // filled in by the decimal side
        segs.dec_tens = `SEG_BLANK;
    end

endmodule

`default_nettype wire

/* scan_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ps2_kbd_consts.svh"

module scan_fifo #(
    parameter type payload_t = ps2_kbd_pkg::scan_byte_t
) (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     wr_en,
    input  wire payload_t wr_data,
    input  wire logic     next_n,
    output payload_t      data,
    output logic          ready,
    output logic          overflow
);

    localparam int DEPTH = `PS2_FIFO_DEPTH;
    localparam int PTR_W = `PS2_PTR_W;
    localparam logic [PTR_W:0] PTR_ONE = 1;

    payload_t         mem [DEPTH];
    logic [PTR_W:0]   wr_ptr;  // top bit counts wraps
    logic [PTR_W:0]   rd_ptr;
    logic             empty;
    logic             full;
    logic             pop;
    logic             push;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    // next_n only counts while there is something to take
    assign pop  = ~empty & ~next_n;
    assign push = wr_en & (~full | pop);  // a pop frees the slot in the same cycle

    assign ready = ~empty;
    assign data  = mem[rd_ptr[PTR_W-1:0]];  // head entry is only valid while ready

    ////////////////////////////////////////////////////////////////////////////
    // pointers and flags
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + PTR_ONE;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + PTR_ONE;
            end
            if (wr_en && !push) begin
                overflow <= 1'b1;  // sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[PTR_W-1:0]] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* ps2_frame_rx.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ps2_kbd_consts.svh"

module ps2_frame_rx (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    ps2_clk,
    input  wire logic                    ps2_data,
    output logic                         byte_valid,
    output ps2_kbd_pkg::scan_byte_t      byte_out
);

    logic [`PS2_SYNC_STAGES-1:0] clk_sync;
    logic [`PS2_SYNC_STAGES-1:0] data_sync;
    logic                        clk_last;
    logic                        clk_fall;
    logic                        data_bit;
    logic [9:0]                  frame;     // start, data lsb first, parity
    logic [3:0]                  bit_cnt;
    logic                        frame_ok;

    ////////////////////////////////////////////////////////////////////////////
    // synchronizers and falling edge detect
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            clk_sync  <= '1;  // idle lines are high
            data_sync <= '1;
            clk_last  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[`PS2_SYNC_STAGES-2:0], ps2_clk};
            data_sync <= {data_sync[`PS2_SYNC_STAGES-2:0], ps2_data};
            clk_last  <= clk_sync[`PS2_SYNC_STAGES-1];
        end
    end

    assign clk_fall = clk_last & ~clk_sync[`PS2_SYNC_STAGES-1];
    assign data_bit = data_sync[`PS2_SYNC_STAGES-1];

    // data_bit is the stop bit when this is looked at
    assign frame_ok = ~frame[0] & data_bit & (^frame[9:1]);

    ////////////////////////////////////////////////////////////////////////////
    // bit counter and frame check
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (clk_fall) begin
                if (bit_cnt == 4'd10) begin
                    bit_cnt    <= '0;  // bad frames are simply dropped
                    byte_valid <= frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_fall) begin
            if (bit_cnt != 4'd10) begin
                frame <= {data_bit, frame[9:1]};  // first bit ends up in frame[0]
            end else if (frame_ok) begin
                byte_out <= frame[8:1];
            end
        end
    end

endmodule

`default_nettype wire

/* ps2_kbd_pkg.sv */
`default_nettype none

package ps2_kbd_pkg;

    // one scan code as it comes off the keyboard
    typedef logic [7:0] scan_byte_t;

    // a 0 lights a segment with a in bit 6 and g in bit 0
    typedef logic [6:0] seg_t;

    // all four digits of the board in one bus
    typedef struct packed {
        seg_t hex_lo;    // low nibble in hex
        seg_t hex_hi;    // high nibble in hex
        seg_t dec_ones;  // ones of the value mod 100
        seg_t dec_tens;  // tens of the value mod 100
    } seg_bank_t;

endpackage

`default_nettype wire

/* ps2_kbd_consts.svh */
`ifndef PS2_KBD_CONSTS_SVH
`define PS2_KBD_CONSTS_SVH

// the scan FIFO depth must be a power of two
`define PS2_FIFO_DEPTH 8
`define PS2_PTR_W ($clog2(`PS2_FIFO_DEPTH))

`define PS2_SYNC_STAGES 2  // flops ahead of the edge register

////////////////////////////////////////////////////////////////////////////
// active-low glyphs with segment a in bit 6 down to segment g in bit 0
////////////////////////////////////////////////////////////////////////////
`define SEG_BLANK   7'b1111111
`define SEG_DIGIT_0 7'b0000001
`define SEG_DIGIT_1 7'b1001111
`define SEG_DIGIT_2 7'b0010010
`define SEG_DIGIT_3 7'b0000110
`define SEG_DIGIT_4 7'b1001100
`define SEG_DIGIT_5 7'b0100100
`define SEG_DIGIT_6 7'b0100000
`define SEG_DIGIT_7 7'b0001111
`define SEG_DIGIT_8 7'b0000000
`define SEG_DIGIT_9 7'b0000100
`define SEG_DIGIT_A 7'b0001000
`define SEG_DIGIT_B 7'b1100000
`define SEG_DIGIT_C 7'b0110001
`define SEG_DIGIT_D 7'b1000010
`define SEG_DIGIT_E 7'b0110000
`define SEG_DIGIT_F 7'b0111000

`endif
